// ==== hw/bus_pkg.sv ====
package bus_pkg;

    // Local register bus geometry
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 8;

    // System register window
    localparam logic [ADDR_WIDTH-1:0] SYS_BASE = 16'h0300;
    localparam logic [ADDR_WIDTH-1:0] SYS_HIGH = 16'h03FF;

    // Base-board control window
    localparam logic [ADDR_WIDTH-1:0] CTRL_BASE = 16'h0500;
    localparam logic [ADDR_WIDTH-1:0] CTRL_HIGH = 16'h05FF;

    // Command loop start pulser window
    localparam logic [ADDR_WIDTH-1:0] PULSE_BASE = 16'h0C00;
    localparam logic [ADDR_WIDTH-1:0] PULSE_HIGH = 16'h0CFF;

    // Request shared by all register blocks
    // addr holds the offset inside the hit window
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } bus_req_t;

    // One select per register block
    typedef struct packed {
        logic sys;
        logic ctrl;
        logic pulse;
    } block_sel_t;

endpackage

// ==== hw/daq_pkg.sv ====
package daq_pkg;

    // Readback identification
    localparam logic [bus_pkg::DATA_WIDTH-1:0] MODULE_VERSION = 8'd1;
    localparam logic [bus_pkg::DATA_WIDTH-1:0] BOARD_SIM      = 8'd0;

    // System register offsets
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] SYS_ADDR_VERSION        = 16'd0;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] SYS_ADDR_MINOR          = 16'd1;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] SYS_ADDR_MAJOR          = 16'd2;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] SYS_ADDR_BOARD          = 16'd3;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] SYS_ADDR_CONFIGURED     = 16'd4;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] SYS_ADDR_SET_CONFIGURED = 16'd5;

    // Control register offsets
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] CTRL_ADDR_LEMO  = 16'd0;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] CTRL_ADDR_NTC   = 16'd1;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] CTRL_ADDR_SENSE = 16'd2;

    // Pulser register offsets
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] PULSE_ADDR_START = 16'd0;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] PULSE_ADDR_DELAY = 16'd1;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] PULSE_ADDR_WIDTH = 16'd2;
    localparam logic [bus_pkg::ADDR_WIDTH-1:0] PULSE_ADDR_BUSY  = 16'd3;

    // Output stream word width
    localparam int STREAM_WIDTH = 32;

    typedef enum logic [1:0] {
        PULSE_IDLE  = 2'd0,
        PULSE_DELAY = 2'd1,
        PULSE_HIGH  = 2'd2
    } pulse_state_t;

    // Word offered to the output stream
    typedef struct packed {
        logic                    valid;
        logic [STREAM_WIDTH-1:0] data;
    } stream_word_t;

endpackage

// ==== hw/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder (
    input  logic                           i_bus_clk,
    input  logic                           i_bus_rst,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] i_bus_add,
    input  logic [bus_pkg::DATA_WIDTH-1:0] i_bus_data,
    input  logic                           i_bus_rd,
    input  logic                           i_bus_wr,
    output bus_pkg::bus_req_t              o_req,
    output bus_pkg::block_sel_t            o_sel,
    input  logic [bus_pkg::DATA_WIDTH-1:0] i_sys_rdata,
    input  logic [bus_pkg::DATA_WIDTH-1:0] i_ctrl_rdata,
    input  logic [bus_pkg::DATA_WIDTH-1:0] i_pulse_rdata,
    output logic [bus_pkg::DATA_WIDTH-1:0] o_bus_data
);

    // Block hit by the last read, selects the returned byte
    bus_pkg::block_sel_t rd_sel;

    // Window match
    always_comb begin
        o_sel.sys   = (i_bus_add >= bus_pkg::SYS_BASE) && (i_bus_add <= bus_pkg::SYS_HIGH);
        o_sel.ctrl  = (i_bus_add >= bus_pkg::CTRL_BASE) && (i_bus_add <= bus_pkg::CTRL_HIGH);
        o_sel.pulse = (i_bus_add >= bus_pkg::PULSE_BASE)
                   && (i_bus_add <= bus_pkg::PULSE_HIGH);
    end

    // Shared request, offset relative to the hit window
    always_comb begin
        o_req.rd    = i_bus_rd;
        o_req.wr    = i_bus_wr;
        o_req.wdata = i_bus_data;
        if (o_sel.sys) begin
            o_req.addr = i_bus_add - bus_pkg::SYS_BASE;
        end else if (o_sel.ctrl) begin
            o_req.addr = i_bus_add - bus_pkg::CTRL_BASE;
        end else if (o_sel.pulse) begin
            o_req.addr = i_bus_add - bus_pkg::PULSE_BASE;
        end else begin
            o_req.addr = '0;
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            rd_sel <= '0;
        end else if (i_bus_rd) begin
            rd_sel <= o_sel;
        end
    end

    // Unmapped reads return zero
    always_comb begin
        if (rd_sel.sys) begin
            o_bus_data = i_sys_rdata;
        end else if (rd_sel.ctrl) begin
            o_bus_data = i_ctrl_rdata;
        end else if (rd_sel.pulse) begin
            o_bus_data = i_pulse_rdata;
        end else begin
            o_bus_data = '0;
        end
    end

endmodule

// ==== hw/system_regs.sv ====
`timescale 1ns/1ns

module system_regs #(
    parameter logic [7:0] VERSION_MAJOR = 8'd0,
    parameter logic [7:0] VERSION_MINOR = 8'd0
) (
    input  logic                           i_bus_clk,
    input  logic                           i_bus_rst,
    input  bus_pkg::bus_req_t              i_req,
    input  logic                           i_sel,
    output logic [bus_pkg::DATA_WIDTH-1:0] o_rdata
);

    logic rd_en;
    logic wr_en;
    // Set by the host once the reference clock is programmed
    logic configured;

    assign rd_en = i_req.rd && i_sel;
    assign wr_en = i_req.wr && i_sel;

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            configured <= 1'b0;
        end else if (wr_en && (i_req.addr == daq_pkg::SYS_ADDR_SET_CONFIGURED)) begin
            configured <= i_req.wdata[0];
        end
    end

    // Readback byte, updated only on a read of this block
    always_ff @(posedge i_bus_clk) begin
        if (rd_en) begin
            case (i_req.addr)
                daq_pkg::SYS_ADDR_VERSION:    o_rdata <= daq_pkg::MODULE_VERSION;
                daq_pkg::SYS_ADDR_MINOR:      o_rdata <= VERSION_MINOR;
                daq_pkg::SYS_ADDR_MAJOR:      o_rdata <= VERSION_MAJOR;
                daq_pkg::SYS_ADDR_BOARD:      o_rdata <= daq_pkg::BOARD_SIM;
                daq_pkg::SYS_ADDR_CONFIGURED: begin
                    o_rdata <= {{(bus_pkg::DATA_WIDTH-1){1'b0}}, configured};
                end
                default:                      o_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== hw/control_regs.sv ====
`timescale 1ns/1ns

module control_regs (
    input  logic                           i_bus_clk,
    input  logic                           i_bus_rst,
    input  bus_pkg::bus_req_t              i_req,
    input  logic                           i_sel,
    output logic [bus_pkg::DATA_WIDTH-1:0] o_rdata,
    input  logic [3:0]                     i_gpio_sense,
    output logic [7:0]                     o_lemo_mux,
    output logic [2:0]                     o_ntc_mux
);

    logic       rd_en;
    logic       wr_en;
    logic [7:0] lemo_reg;
    logic [2:0] ntc_reg;
    // Two-flop synchronizer for the asynchronous sense lines
    logic [3:0] sense_meta;
    logic [3:0] sense_sync;

    assign rd_en = i_req.rd && i_sel;
    assign wr_en = i_req.wr && i_sel;

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            lemo_reg <= '0;
            ntc_reg  <= '0;
        end else if (wr_en) begin
            case (i_req.addr)
                daq_pkg::CTRL_ADDR_LEMO: lemo_reg <= i_req.wdata;
                daq_pkg::CTRL_ADDR_NTC:  ntc_reg  <= i_req.wdata[2:0];
                default:                 ;
            endcase
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            sense_meta <= '0;
            sense_sync <= '0;
        end else begin
            sense_meta <= i_gpio_sense;
            sense_sync <= sense_meta;
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (rd_en) begin
            case (i_req.addr)
                daq_pkg::CTRL_ADDR_LEMO:  o_rdata <= lemo_reg;
                daq_pkg::CTRL_ADDR_NTC:   o_rdata <= {5'b0, ntc_reg};
                daq_pkg::CTRL_ADDR_SENSE: o_rdata <= {4'b0, sense_sync};
                default:                  o_rdata <= '0;
            endcase
        end
    end

    // Multiplexer lines follow the registers directly
    assign o_lemo_mux = lemo_reg;
    assign o_ntc_mux  = ntc_reg;

endmodule

// ==== hw/pulse_gen.sv ====
`timescale 1ns/1ns

module pulse_gen (
    input  logic                           i_bus_clk,
    input  logic                           i_bus_rst,
    input  bus_pkg::bus_req_t              i_req,
    input  logic                           i_sel,
    output logic [bus_pkg::DATA_WIDTH-1:0] o_rdata,
    output logic                           o_pulse
);

    logic                  rd_en;
    logic                  wr_en;
    logic                  start;
    logic [7:0]            delay_reg;
    logic [7:0]            width_reg;
    // Remaining cycles in the current state, minus one
    logic [7:0]            cnt;
    logic [7:0]            width_load;
    daq_pkg::pulse_state_t state;

    assign rd_en = i_req.rd && i_sel;
    assign wr_en = i_req.wr && i_sel;
    assign start = wr_en && (i_req.addr == daq_pkg::PULSE_ADDR_START);

    // WIDTH 0 behaves as 1
    assign width_load = (width_reg == 8'd0) ? 8'd0 : width_reg - 8'd1;

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            delay_reg <= '0;
            width_reg <= '0;
        end else if (wr_en) begin
            case (i_req.addr)
                daq_pkg::PULSE_ADDR_DELAY: delay_reg <= i_req.wdata;
                daq_pkg::PULSE_ADDR_WIDTH: width_reg <= i_req.wdata;
                default:                   ;
            endcase
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            state <= daq_pkg::PULSE_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                daq_pkg::PULSE_IDLE: begin
                    // Start is only taken while idle
                    if (start && (delay_reg == 8'd0)) begin
                        state <= daq_pkg::PULSE_HIGH;
                        cnt   <= width_load;
                    end else if (start) begin
                        state <= daq_pkg::PULSE_DELAY;
                        cnt   <= delay_reg - 8'd1;
                    end
                end
                daq_pkg::PULSE_DELAY: begin
                    if (cnt == 8'd0) begin
                        state <= daq_pkg::PULSE_HIGH;
                        cnt   <= width_load;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                daq_pkg::PULSE_HIGH: begin
                    if (cnt == 8'd0) begin
                        state <= daq_pkg::PULSE_IDLE;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                default: state <= daq_pkg::PULSE_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (rd_en) begin
            case (i_req.addr)
                daq_pkg::PULSE_ADDR_DELAY: o_rdata <= delay_reg;
                daq_pkg::PULSE_ADDR_WIDTH: o_rdata <= width_reg;
                daq_pkg::PULSE_ADDR_BUSY:  o_rdata <= {7'b0, state != daq_pkg::PULSE_IDLE};
                default:                   o_rdata <= '0;
            endcase
        end
    end

    assign o_pulse = (state == daq_pkg::PULSE_HIGH);

endmodule

// ==== hw/stream_arbiter.sv ====
`timescale 1ns/1ns

module stream_arbiter #(
    parameter int N_SOURCES = 3
) (
    input  logic                                       i_bus_clk,
    input  logic                                       i_bus_rst,
    input  logic [N_SOURCES-1:0]                       i_src_empty,
    input  logic [N_SOURCES*daq_pkg::STREAM_WIDTH-1:0] i_src_data,
    output logic [N_SOURCES-1:0]                       o_src_read,
    input  logic                                       i_arb_ready,
    output logic                                       o_arb_write,
    output logic [daq_pkg::STREAM_WIDTH-1:0]           o_arb_data
);

    localparam int PTR_W = $clog2(N_SOURCES);

    // Search start for the next pick
    logic [PTR_W-1:0]      ptr;
    // Held choice while the output is stalled
    logic                  locked;
    logic [PTR_W-1:0]      held_idx;
    logic [PTR_W-1:0]      search_idx;
    logic [PTR_W-1:0]      chosen;
    logic                  xfer;
    daq_pkg::stream_word_t word;

    // First non-empty source at or after ptr, wrapping
    always_comb begin
        int  idx;
        logic found;
        search_idx = ptr;
        found      = 1'b0;
        for (int i = 0; i < N_SOURCES; i++) begin
            idx = int'(ptr) + i;
            if (idx >= N_SOURCES) begin
                idx = idx - N_SOURCES;
            end
            if (!found && !i_src_empty[idx]) begin
                search_idx = PTR_W'(idx);
                found      = 1'b1;
            end
        end
    end

    assign chosen     = locked ? held_idx : search_idx;
    assign word.valid = !i_src_empty[chosen];
    assign word.data  = i_src_data[chosen*daq_pkg::STREAM_WIDTH +: daq_pkg::STREAM_WIDTH];
    assign xfer       = word.valid && i_arb_ready;

    always_comb begin
        o_src_read = '0;
        o_src_read[chosen] = xfer;
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            ptr      <= '0;
            locked   <= 1'b0;
            held_idx <= '0;
        end else if (xfer) begin
            locked <= 1'b0;
            ptr    <= (chosen == PTR_W'(N_SOURCES - 1)) ? '0 : chosen + 1'b1;
        end else if (word.valid) begin
            // Back-pressure, keep offering the same word
            locked   <= 1'b1;
            held_idx <= chosen;
        end
    end

    assign o_arb_write = word.valid;
    assign o_arb_data  = word.data;

endmodule

// ==== hw/daq_core.sv ====
`timescale 1ns/1ns

module daq_core #(
    parameter logic [7:0] VERSION_MAJOR = 8'd2,
    parameter logic [7:0] VERSION_MINOR = 8'd5,
    parameter int         N_SOURCES     = 3
) (
    input  logic                                       BUS_CLK,
    input  logic                                       BUS_RST,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]             i_bus_add,
    input  logic [bus_pkg::DATA_WIDTH-1:0]             i_bus_data,
    input  logic                                       i_bus_rd,
    input  logic                                       i_bus_wr,
    output logic [bus_pkg::DATA_WIDTH-1:0]             o_bus_data,
    input  logic [3:0]                                 i_gpio_sense,
    output logic [7:0]                                 o_lemo_mux,
    output logic [2:0]                                 o_ntc_mux,
    output logic                                       o_pulse,
    input  logic [N_SOURCES-1:0]                       i_src_empty,
    input  logic [N_SOURCES*daq_pkg::STREAM_WIDTH-1:0] i_src_data,
    output logic [N_SOURCES-1:0]                       o_src_read,
    input  logic                                       i_arb_ready,
    output logic                                       o_arb_write,
    output logic [daq_pkg::STREAM_WIDTH-1:0]           o_arb_data
);

    bus_pkg::bus_req_t              bus_req;
    bus_pkg::block_sel_t            bus_sel;
    logic [bus_pkg::DATA_WIDTH-1:0] sys_rdata;
    logic [bus_pkg::DATA_WIDTH-1:0] ctrl_rdata;
    logic [bus_pkg::DATA_WIDTH-1:0] pulse_rdata;

    bus_decoder bus_decoder_i (
        .i_bus_clk     (BUS_CLK),
        .i_bus_rst     (BUS_RST),
        .i_bus_add     (i_bus_add),
        .i_bus_data    (i_bus_data),
        .i_bus_rd      (i_bus_rd),
        .i_bus_wr      (i_bus_wr),
        .o_req         (bus_req),
        .o_sel         (bus_sel),
        .i_sys_rdata   (sys_rdata),
        .i_ctrl_rdata  (ctrl_rdata),
        .i_pulse_rdata (pulse_rdata),
        .o_bus_data    (o_bus_data)
    );

    system_regs #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR)
    ) system_regs_i (
        .i_bus_clk (BUS_CLK),
        .i_bus_rst (BUS_RST),
        .i_req     (bus_req),
        .i_sel     (bus_sel.sys),
        .o_rdata   (sys_rdata)
    );

    control_regs control_regs_i (
        .i_bus_clk    (BUS_CLK),
        .i_bus_rst    (BUS_RST),
        .i_req        (bus_req),
        .i_sel        (bus_sel.ctrl),
        .o_rdata      (ctrl_rdata),
        .i_gpio_sense (i_gpio_sense),
        .o_lemo_mux   (o_lemo_mux),
        .o_ntc_mux    (o_ntc_mux)
    );

    // Command loop start pulser
    pulse_gen pulse_gen_i (
        .i_bus_clk (BUS_CLK),
        .i_bus_rst (BUS_RST),
        .i_req     (bus_req),
        .i_sel     (bus_sel.pulse),
        .o_rdata   (pulse_rdata),
        .o_pulse   (o_pulse)
    );

    stream_arbiter #(
        .N_SOURCES (N_SOURCES)
    ) stream_arbiter_i (
        .i_bus_clk   (BUS_CLK),
        .i_bus_rst   (BUS_RST),
        .i_src_empty (i_src_empty),
        .i_src_data  (i_src_data),
        .o_src_read  (o_src_read),
        .i_arb_ready (i_arb_ready),
        .o_arb_write (o_arb_write),
        .o_arb_data  (o_arb_data)
    );

endmodule

// ==== tests/daq_core_assertions.sv ====
`timescale 1ns/1ns

module daq_core_assertions #(
    parameter int N_SOURCES = 3
) (
    input logic                             i_bus_clk,
    input logic                             i_bus_rst,
    input logic                             i_pulse,
    input logic [N_SOURCES-1:0]             i_src_read,
    input logic                             i_arb_ready,
    input logic                             i_arb_write,
    input logic [daq_pkg::STREAM_WIDTH-1:0] i_arb_data
);

    // At most one source popped per cycle
    read_onehot: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        $onehot0(i_src_read))
        else $error("more than one source read in one cycle");

    // A pop only happens together with a transfer
    read_on_xfer: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        (|i_src_read) |-> (i_arb_ready && i_arb_write))
        else $error("source read without a stream transfer");

    // Stalled word is held
    data_held: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        (i_arb_write && !i_arb_ready) |=> $stable(i_arb_data))
        else $error("stream data changed under back-pressure");

    reset_quiet: assert property (@(posedge i_bus_clk)
        i_bus_rst |=> (!i_pulse && !i_arb_write))
        else $error("pulse or stream write active right after reset");

endmodule

bind daq_core daq_core_assertions #(
    .N_SOURCES (N_SOURCES)
) assertions_i (
    .i_bus_clk   (BUS_CLK),
    .i_bus_rst   (BUS_RST),
    .i_pulse     (o_pulse),
    .i_src_read  (o_src_read),
    .i_arb_ready (i_arb_ready),
    .i_arb_write (o_arb_write),
    .i_arb_data  (o_arb_data)
);

// ==== tests/tb_daq_core.sv ====
`timescale 1ns/1ns

module tb_daq_core;

    localparam int N_SRC = 3;
    localparam int SW    = daq_pkg::STREAM_WIDTH;

    // One bus operation plus the address and value of its read-back
    typedef struct packed {
        logic        is_write;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic [15:0] chk_addr;
        logic [7:0]  expected;
    } bus_op_t;

    typedef struct packed {
        logic [7:0] delay;
        logic [7:0] width;
    } pulse_op_t;

    localparam int N_BUS_OPS = 15;
    localparam bus_op_t BUS_TABLE [N_BUS_OPS] = '{
        '{1'b0, 16'h0300, 8'h00, 16'h0300, 8'h01},
        '{1'b0, 16'h0301, 8'h00, 16'h0301, 8'h05},
        '{1'b0, 16'h0302, 8'h00, 16'h0302, 8'h02},
        '{1'b0, 16'h0303, 8'h00, 16'h0303, 8'h00},
        '{1'b0, 16'h0304, 8'h00, 16'h0304, 8'h00},
        '{1'b0, 16'h0306, 8'h00, 16'h0306, 8'h00},
        '{1'b0, 16'h0700, 8'h00, 16'h0700, 8'h00},
        '{1'b1, 16'h0305, 8'h01, 16'h0304, 8'h01},
        '{1'b1, 16'h0305, 8'h00, 16'h0304, 8'h00},
        '{1'b1, 16'h0500, 8'hA5, 16'h0500, 8'hA5},
        '{1'b1, 16'h0501, 8'h06, 16'h0501, 8'h06},
        '{1'b1, 16'h0500, 8'h3C, 16'h0500, 8'h3C},
        '{1'b1, 16'h0501, 8'h0F, 16'h0501, 8'h07},
        '{1'b1, 16'h0C01, 8'h07, 16'h0C01, 8'h07},
        '{1'b1, 16'h0C02, 8'h03, 16'h0C02, 8'h03}
    };

    localparam logic [3:0] SENSE_TABLE [5] = '{4'h0, 4'h5, 4'hA, 4'hF, 4'h3};

    localparam pulse_op_t PULSE_TABLE [6] = '{
        '{8'd0, 8'd0}, '{8'd0, 8'd1}, '{8'd3, 8'd2},
        '{8'd1, 8'd5}, '{8'd10, 8'd0}, '{8'd7, 8'd3}
    };

    logic                BUS_CLK;
    logic                BUS_RST;
    logic [15:0]         i_bus_add;
    logic [7:0]          i_bus_data;
    logic                i_bus_rd;
    logic                i_bus_wr;
    logic [7:0]          o_bus_data;
    logic [3:0]          i_gpio_sense;
    logic [7:0]          o_lemo_mux;
    logic [2:0]          o_ntc_mux;
    logic                o_pulse;
    logic [N_SRC-1:0]    i_src_empty;
    logic [N_SRC*SW-1:0] i_src_data;
    logic [N_SRC-1:0]    o_src_read;
    logic                i_arb_ready;
    logic                o_arb_write;
    logic [SW-1:0]       o_arb_data;

    logic [31:0]   lfsr_state;
    // FIFO models of the three stream sources
    logic [SW-1:0] src_q [N_SRC][$];
    bit            seen [logic [SW-1:0]];
    int            model_ptr;
    int            pushed;
    int            received;
    int            serial;

    daq_core dut_i (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_bus_add    (i_bus_add),
        .i_bus_data   (i_bus_data),
        .i_bus_rd     (i_bus_rd),
        .i_bus_wr     (i_bus_wr),
        .o_bus_data   (o_bus_data),
        .i_gpio_sense (i_gpio_sense),
        .o_lemo_mux   (o_lemo_mux),
        .o_ntc_mux    (o_ntc_mux),
        .o_pulse      (o_pulse),
        .i_src_empty  (i_src_empty),
        .i_src_data   (i_src_data),
        .o_src_read   (o_src_read),
        .i_arb_ready  (i_arb_ready),
        .o_arb_write  (o_arb_write),
        .o_arb_data   (o_arb_data)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #10 BUS_CLK = ~BUS_CLK;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        #2;
        i_bus_add  = addr;
        i_bus_data = data;
        i_bus_wr   = 1'b1;
        @(posedge BUS_CLK);
        #2;
        i_bus_wr = 1'b0;
    endtask

    // Read data is valid in the cycle after the strobe
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        #2;
        i_bus_add = addr;
        i_bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #2;
        i_bus_rd = 1'b0;
        @(negedge BUS_CLK);
        data = o_bus_data;
    endtask

    task automatic run_pulse(input pulse_op_t op);
        int   n;
        int   first;
        int   fell;
        int   high_cycles;
        int   exp_width;
        logic prev_pulse;
        bus_write(bus_pkg::PULSE_BASE + daq_pkg::PULSE_ADDR_DELAY, op.delay);
        bus_write(bus_pkg::PULSE_BASE + daq_pkg::PULSE_ADDR_WIDTH, op.width);
        exp_width = (op.width == 8'd0) ? 1 : int'(op.width);
        @(posedge BUS_CLK);
        #2;
        i_bus_add  = bus_pkg::PULSE_BASE + daq_pkg::PULSE_ADDR_START;
        i_bus_data = 8'h00;
        i_bus_wr   = 1'b1;
        @(posedge BUS_CLK);
        #2;
        i_bus_wr = 1'b0;
        // BUSY read every cycle and each byte shows the cycle before
        i_bus_add = bus_pkg::PULSE_BASE + daq_pkg::PULSE_ADDR_BUSY;
        i_bus_rd  = 1'b1;
        n           = 1;
        first       = 0;
        fell        = 0;
        high_cycles = 0;
        prev_pulse  = 1'b0;
        while (fell == 0) begin
            if (n > 600) begin
                stop_on_error("pulse did not complete within 600 cycles");
            end
            @(negedge BUS_CLK);
            if (prev_pulse) begin
                check_value("o_bus_data (busy during pulse)", 32'(o_bus_data), 32'h1);
            end
            if (o_pulse) begin
                if (first == 0) begin
                    first = n;
                end
                high_cycles++;
            end else if (first != 0) begin
                fell = n;
            end
            prev_pulse = o_pulse;
            n++;
            @(posedge BUS_CLK);
            #2;
        end
        @(negedge BUS_CLK);
        check_value("o_bus_data (busy after pulse)", 32'(o_bus_data), 32'h0);
        i_bus_rd = 1'b0;
        check_value("o_pulse start cycle", 32'(first), 32'(int'(op.delay) + 1));
        check_value("o_pulse width", 32'(high_cycles), 32'(exp_width));
    endtask

    task automatic push_word(input int k);
        src_q[k].push_back({4'(k), 28'(serial)});
        serial++;
        pushed++;
    endtask

    function automatic int queued_words();
        int n;
        n = 0;
        for (int k = 0; k < N_SRC; k++) begin
            n += src_q[k].size();
        end
        return n;
    endfunction

    task automatic drive_sources();
        for (int k = 0; k < N_SRC; k++) begin
            i_src_empty[k] = (src_q[k].size() == 0);
            i_src_data[k*SW +: SW] = (src_q[k].size() == 0) ? '0 : src_q[k][0];
        end
    endtask

    // Cycle-by-cycle stream run against the round-robin reference model
    task automatic run_stream(input logic gaps, input int refills, input logic strict);
        int               cycles;
        int               refills_left;
        int               order;
        int               pick;
        int               held_pick;
        int               k;
        logic             any;
        logic             found;
        logic             held;
        logic [1:0]       sel;
        logic [SW-1:0]    word;
        logic [N_SRC-1:0] exp_read;
        cycles       = 0;
        refills_left = refills;
        order        = 0;
        held         = 1'b0;
        held_pick    = 0;
        while (queued_words() > 0 || refills_left > 0) begin
            if (cycles >= 4000) begin
                stop_on_error("stream sources did not drain within 4000 cycles");
            end
            cycles++;
            @(posedge BUS_CLK);
            #2;
            if (refills_left > 0 && next_random_bit() && next_random_bit()) begin
                sel = {next_random_bit(), next_random_bit()};
                if (sel != 2'd3) begin
                    push_word(int'(sel));
                    refills_left--;
                end
            end
            i_arb_ready = gaps ? (next_random_bit() | next_random_bit()) : 1'b1;
            drive_sources();
            @(negedge BUS_CLK);
            pick  = model_ptr;
            found = 1'b0;
            if (held) begin
                pick = held_pick;
            end else begin
                for (int i = 0; i < N_SRC; i++) begin
                    k = (model_ptr + i) % N_SRC;
                    if (!found && src_q[k].size() != 0) begin
                        pick  = k;
                        found = 1'b1;
                    end
                end
            end
            any = (src_q[pick].size() != 0);
            check_value("o_arb_write", 32'(o_arb_write), 32'(any));
            if (any) begin
                check_value("o_arb_data", o_arb_data, src_q[pick][0]);
            end
            exp_read = '0;
            if (any && i_arb_ready) begin
                exp_read[pick] = 1'b1;
            end
            check_value("o_src_read", 32'(o_src_read), 32'(exp_read));
            // Word delivered on the stream as seen at the DUT outputs
            if (o_arb_write && i_arb_ready) begin
                word = o_arb_data;
                if (seen.exists(word)) begin
                    stop_on_error($sformatf("word 0x%0h was delivered twice", word));
                end
                seen[word] = 1'b1;
                received++;
                if (strict) begin
                    check_value("o_src_read source order", 32'(o_src_read),
                                32'(1 << (order % N_SRC)));
                end
                order++;
            end
            // Each source pops on its own read strobe
            for (int s = 0; s < N_SRC; s++) begin
                if (o_src_read[s] && src_q[s].size() != 0) begin
                    src_q[s].delete(0);
                end
            end
            if (any && i_arb_ready) begin
                held      = 1'b0;
                model_ptr = (pick + 1) % N_SRC;
            end else if (any) begin
                held      = 1'b1;
                held_pick = pick;
            end
        end
        @(posedge BUS_CLK);
        #2;
        i_arb_ready = 1'b0;
        drive_sources();
        check_value("words delivered", 32'(received), 32'(pushed));
    endtask

    initial begin
        bus_op_t    op;
        logic [7:0] rdata;
        lfsr_state   = 32'ha3bdcb41;
        model_ptr    = 0;
        pushed       = 0;
        received     = 0;
        serial       = 0;
        BUS_RST      = 1'b1;
        i_bus_add    = '0;
        i_bus_data   = '0;
        i_bus_rd     = 1'b0;
        i_bus_wr     = 1'b0;
        i_gpio_sense = '0;
        i_src_empty  = '1;
        i_src_data   = '0;
        i_arb_ready  = 1'b0;
        repeat (16) @(posedge BUS_CLK);
        #2;
        BUS_RST = 1'b0;
        @(negedge BUS_CLK);
        check_value("o_pulse", 32'(o_pulse), 32'h0);
        check_value("o_arb_write", 32'(o_arb_write), 32'h0);
        check_value("o_src_read", 32'(o_src_read), 32'h0);
        check_value("o_lemo_mux", 32'(o_lemo_mux), 32'h0);
        check_value("o_ntc_mux", 32'(o_ntc_mux), 32'h0);

        for (int i = 0; i < N_BUS_OPS; i++) begin
            op = BUS_TABLE[i];
            if (op.is_write) begin
                bus_write(op.addr, op.wdata);
                @(negedge BUS_CLK);
                if (op.addr == 16'h0500) begin
                    check_value("o_lemo_mux", 32'(o_lemo_mux), 32'(op.wdata));
                end
                if (op.addr == 16'h0501) begin
                    check_value("o_ntc_mux", 32'(o_ntc_mux), 32'(op.wdata[2:0]));
                end
            end
            bus_read(op.chk_addr, rdata);
            check_value($sformatf("o_bus_data @0x%04h", op.chk_addr), 32'(rdata),
                        32'(op.expected));
        end

        // Sense lines settle through the synchronizer first
        for (int i = 0; i < 5; i++) begin
            @(posedge BUS_CLK);
            #2;
            i_gpio_sense = SENSE_TABLE[i];
            repeat (4) @(posedge BUS_CLK);
            bus_read(16'h0502, rdata);
            check_value("o_bus_data @0x0502", 32'(rdata), 32'(SENSE_TABLE[i]));
        end

        for (int i = 0; i < 6; i++) begin
            run_pulse(PULSE_TABLE[i]);
        end

        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < N_SRC; k++) begin
                push_word(k);
            end
        end
        run_stream(1'b0, 0, 1'b1);

        for (int j = 0; j < 5; j++) begin
            for (int k = 0; k < N_SRC; k++) begin
                push_word(k);
            end
        end
        run_stream(1'b1, 30, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== build.f ====
hw/bus_pkg.sv
hw/daq_pkg.sv
hw/bus_decoder.sv
hw/system_regs.sv
hw/control_regs.sv
hw/pulse_gen.sv
hw/stream_arbiter.sv
hw/daq_core.sv
tests/daq_core_assertions.sv
tests/tb_daq_core.sv

// ==== Makefile ====
TOP := tb_daq_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir
